// ==== project.f ====
rtl/stack_pkg.sv
rtl/stack_mem.sv
rtl/stack_ptr.sv
rtl/stack_alu.sv
rtl/stack_ctrl.sv
rtl/stack_readback.sv
rtl/stack_unit_top.sv
testbench/tb_stack_unit.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_stack_unit
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = >>> PASS

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1 || true
	@if grep -q -F -- '$(PASS)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/tb_stack_unit.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the stack coprocessor
// AXI4-Lite bus tasks, queue reference model and response monitor
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_stack_unit
    import stack_pkg::*;
();

    localparam int timeout = 64;        // cycles per wait loop

    logic        clk = 1'b0;
    logic        arst_n;
    logic        awvalid;
    logic        awready;
    logic [3:0]  awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [3:0]  araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    logic [31:0] model_q[$];            // model stack with top at the back
    logic        model_err;
    logic [1:0]  exp_b_q[$];            // expected responses in issue order
    logic [31:0] exp_rdata_q[$];
    logic [1:0]  exp_rresp_q[$];
    logic [31:0] lcg_state;
    logic        stall_en;              // random back-pressure on B and R
    logic        b_stalled = 1'b0;
    logic        r_stalled = 1'b0;
    logic [1:0]  b_prev = 2'b00;
    logic [31:0] r_prev = 32'd0;

    stack_unit_top i_dut (
        .clk, .arst_n, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .rvalid, .rready,
        .rdata, .rresp
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            abort_run($sformatf("ERR %0t %s: got %h, expected %h", $time, what, got, want));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int stall_span(input int min_cycles);
        if (!stall_en) return min_cycles;
        return min_cycles + int'((lcg_next() >> 16) % 32'd5);  // 0 to 4 extra cycles
    endfunction

    // expected bresp of one write and the model stack and sticky flag it leaves
    function automatic logic [1:0] model_word(input logic [3:0] addr, input logic [31:0] data);
        int          n;
        int          need_n;
        logic        grows;
        logic [31:0] a;
        logic [31:0] b;
        n = model_q.size();
        if (addr == reg_data) begin
            if (n == depth) begin
                model_err = 1'b1;               // overflow
                return resp_slverr;
            end
            model_q.push_back(data);
            return resp_okay;
        end
        if (addr != reg_cmd || data[3:0] > 4'd9) return resp_slverr;  // no sticky here
        if (data[3:0] == op_clr) begin
            model_q.delete();
            model_err = 1'b0;
            return resp_okay;
        end
        need_n = (data[3:0] <= op_dup) ? 1 : 2;
        grows  = (data[3:0] == op_dup) || (data[3:0] == op_over);
        if (n < need_n || (grows && n == depth)) begin
            model_err = 1'b1;
            return resp_slverr;
        end
        a = model_q[n-1];                       // top
        b = (n > 1) ? model_q[n-2] : 32'd0;     // next
        case (data[3:0])
            op_drop: void'(model_q.pop_back());
            op_dup:  model_q.push_back(a);
            op_swap: begin
                model_q[n-1] = b;
                model_q[n-2] = a;
            end
            op_over: model_q.push_back(b);
            default: begin
                void'(model_q.pop_back());      // two in, one out
                case (data[3:0])
                    op_add:  model_q[n-2] = b + a;
                    op_sub:  model_q[n-2] = b - a;
                    op_and:  model_q[n-2] = b & a;
                    op_or:   model_q[n-2] = b | a;
                    default: model_q[n-2] = b ^ a;
                endcase
            end
        endcase
        return resp_okay;
    endfunction

    function automatic logic [31:0] model_tos();
        return (model_q.size() == 0) ? 32'd0 : model_q[$];
    endfunction

    function automatic logic [31:0] model_status();
        logic [31:0] s;
        s       = 32'd0;
        s[4:0]  = 5'(model_q.size());
        s[8]    = (model_q.size() == 0);        // empty
        s[9]    = (model_q.size() == depth);    // full
        s[16]   = model_err;
        return s;
    endfunction

    task automatic start_write(input logic [3:0] addr, input logic [31:0] data,
                               input logic [1:0] want);
        int cnt;
        cnt = 0;
        exp_b_q.push_back(want);
        @(negedge clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        do begin
            @(posedge clk);
            cnt++;
            if (cnt > timeout) abort_run("timeout: write address and data never accepted");
        end while (!(awready && wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic finish_b(input int min_stall);
        int span;
        int held;
        int cnt;
        span = stall_span(min_stall);
        held = 0;
        cnt  = 0;
        do begin
            @(negedge clk);
            bready = (held >= span);            // stall counts only once bvalid is up
            @(posedge clk);
            if (bvalid && !bready) held++;
            cnt++;
            if (cnt > timeout) abort_run("timeout: write response channel never completed");
        end while (!(bvalid && bready));
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, input logic [31:0] want_data,
                            input logic [1:0] want_resp);
        int span;
        int held;
        int cnt;
        span = stall_span(0);
        held = 0;
        cnt  = 0;
        exp_rdata_q.push_back(want_data);
        exp_rresp_q.push_back(want_resp);
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        do begin
            @(posedge clk);
            cnt++;
            if (cnt > timeout) abort_run("timeout: read address never accepted");
        end while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        cnt     = 0;
        do begin
            @(negedge clk);
            rready = (held >= span);
            @(posedge clk);
            if (rvalid && !rready) held++;
            cnt++;
            if (cnt > timeout) abort_run("timeout: read data channel never completed");
        end while (!(rvalid && rready));
        @(negedge clk);
        rready = 1'b0;
    endtask

    // one write then top of stack and status reads against the model
    task automatic run_word(input logic [3:0] addr, input logic [31:0] data);
        logic [1:0] want;
        want = model_word(addr, data);
        start_write(addr, data, want);
        finish_b(0);
        read_reg(reg_tos, model_tos(), resp_okay);
        read_reg(reg_status, model_status(), resp_okay);
    endtask

    task automatic random_word();
        logic [31:0] r;
        logic [3:0]  k;
        logic [3:0]  op_bits;
        r       = lcg_next();
        k       = r[19:16];
        op_bits = (k - 4'd5) % 4'd9;            // drop .. xor
        if (k < 4'd5) begin
            run_word(reg_data, lcg_next());
        end else if (k == 4'd15) begin
            run_word(reg_cmd, {r[31:4], 4'(op_clr)});
        end else begin
            run_word(reg_cmd, {r[31:4], op_bits});  // upper bits must be ignored
        end
    endtask

    // second write presented while the first B is stalled
    task automatic overlap_writes(input logic [31:0] first, input logic [31:0] second);
        logic [1:0] want;
        want = model_word(reg_data, first);
        start_write(reg_data, first, want);
        want = model_word(reg_data, second);
        fork
            start_write(reg_data, second, want);
            finish_b(3);
        join
        finish_b(0);
        read_reg(reg_tos, model_tos(), resp_okay);
        read_reg(reg_status, model_status(), resp_okay);
    endtask

    // response monitor
    always @(posedge clk) begin
        if (arst_n) begin
            check_equal(32'(bvalid && exp_b_q.size() == 0), 32'd0, "bvalid with no write pending");
            check_equal(32'(rvalid && exp_rdata_q.size() == 0), 32'd0,
                        "rvalid with no read pending");
            check_equal(32'(awready && bvalid), 32'd0, "write accepted before B completed");
            if (b_stalled) check_equal(32'({bvalid, bresp}), 32'({1'b1, b_prev}), "B held");
            if (r_stalled) check_equal(rdata, r_prev, "rdata held");
            if (r_stalled) check_equal(32'(rvalid), 32'd1, "rvalid held");
            if (bvalid && bready) check_equal(32'(bresp), 32'(exp_b_q.pop_front()), "bresp");
            if (rvalid && rready) begin
                check_equal(rdata, exp_rdata_q.pop_front(), "rdata");
                check_equal(32'(rresp), 32'(exp_rresp_q.pop_front()), "rresp");
            end
            b_stalled = bvalid && !bready;
            b_prev    = bresp;
            r_stalled = rvalid && !rready;
            r_prev    = rdata;
        end
    end

    initial begin
        arst_n    = 1'b0;
        awvalid   = 1'b0;
        awaddr    = 4'h0;
        wvalid    = 1'b0;
        wdata     = 32'd0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = 4'h0;
        rready    = 1'b0;
        model_err = 1'b0;
        lcg_state = 32'd27;
        stall_en  = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        repeat (4) @(negedge clk);              // idle while monitor flags stray valids

        read_reg(reg_status, model_status(), resp_okay);
        read_reg(reg_tos, 32'd0, resp_okay);

        repeat (depth) run_word(reg_data, lcg_next());  // fill to full

        run_word(reg_data, 32'hdead_beef);      // refused at full
        run_word(reg_cmd, 32'(op_clr));
        run_word(reg_cmd, 32'(op_drop));        // refused when empty
        run_word(reg_cmd, 32'(op_clr));

        repeat (300) random_word();

        run_word(reg_tos, 32'h1234_5678);       // read-only offset
        run_word(4'h2, 32'h0);
        run_word(reg_cmd, 32'hA);               // unused codes
        run_word(reg_cmd, 32'hF);
        read_reg(reg_cmd, 32'd0, resp_slverr);
        read_reg(4'h6, 32'd0, resp_slverr);

        stall_en = 1'b1;
        overlap_writes(lcg_next(), lcg_next());
        repeat (100) random_word();

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/stack_unit_top.sv ====
//////////////////////////////////////////////////////////////////////
// stack coprocessor top, AXI4-Lite slave
//////////////////////////////////////////////////////////////////////
`default_nettype none

module stack_unit_top
    import stack_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        awvalid,
    output logic             awready,
    input  wire logic [3:0]  awaddr,
    input  wire logic        wvalid,
    output logic             wready,
    input  wire logic [31:0] wdata,
    output logic             bvalid,
    input  wire logic        bready,
    output logic [1:0]       bresp,
    input  wire logic        arvalid,
    output logic             arready,
    input  wire logic [3:0]  araddr,
    output logic             rvalid,
    input  wire logic        rready,
    output logic [31:0]      rdata,
    output logic [1:0]       rresp
);

    opcode_e            op;
    resp_e              bresp_e;
    resp_e              rresp_e;
    cell_t              push_data;
    cell_t              tos;
    cell_t              nos;
    cell_t              res_top;
    cell_t              res_nos;
    logic               exec;
    logic               clr;
    logic               fault;
    logic               err;
    logic               we_top;
    logic               we_nos;
    logic [1:0]         need;
    logic [1:0]         delta;
    logic [depth_w-1:0] depth;
    logic [addr_w-1:0]  top_addr;
    logic [addr_w-1:0]  nos_addr;
    logic [addr_w-1:0]  new_top_addr;
    logic [addr_w-1:0]  new_nos_addr;

    assign bresp = bresp_e;
    assign rresp = rresp_e;

    stack_ctrl i_ctrl (
        .clk, .arst_n, .awvalid, .awaddr, .wvalid, .wdata, .bready, .fault,
        .awready, .wready, .bvalid, .bresp(bresp_e), .op, .push_data,
        .exec, .clr, .need, .delta, .we_top, .we_nos, .err
    );

    stack_ptr i_ptr (
        .clk, .arst_n, .exec, .clr, .need, .delta, .fault, .depth,
        .top_addr, .nos_addr, .new_top_addr, .new_nos_addr
    );

    stack_mem i_mem (
        .clk, .top_addr, .nos_addr,
        .we_top, .wtop_addr(new_top_addr), .wtop_data(res_top),   // writes at post-word slots
        .we_nos, .wnos_addr(new_nos_addr), .wnos_data(res_nos),
        .tos, .nos
    );

    stack_alu i_alu (
        .op, .tos, .nos, .push_data, .res_top, .res_nos
    );

    stack_readback i_readback (
        .clk, .arst_n, .arvalid, .araddr, .rready, .tos, .depth, .err,
        .arready, .rvalid, .rdata, .rresp(rresp_e)
    );

endmodule

`default_nettype wire

// ==== rtl/stack_readback.sv ====
//////////////////////////////////////////////////////////////////////
// AXI4-Lite read channel
// registers top of stack or status word for one outstanding read
//////////////////////////////////////////////////////////////////////
`default_nettype none

module stack_readback
    import stack_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               arvalid,
    input  wire logic [3:0]         araddr,
    input  wire logic               rready,
    input  wire cell_t              tos,
    input  wire logic [depth_w-1:0] depth,
    input  wire logic               err,
    output logic                    arready,
    output logic                    rvalid,
    output cell_t                   rdata,
    output resp_e                   rresp
);

    logic  empty;
    logic  full;
    cell_t status;

    assign empty   = (depth == '0);
    assign full    = (depth == depth_w'(stack_pkg::depth));
    assign arready = !rvalid;           // one read in flight

    always_comb begin
        status                = '0;
        status[depth_w-1:0]   = depth;
        status[st_empty]      = empty;
        status[st_full]       = full;
        status[st_err]        = err;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            case (araddr)
                reg_tos: begin
                    rdata <= empty ? '0 : tos;  // stale cell hidden
                    rresp <= resp_okay;
                end
                reg_status: begin
                    rdata <= status;
                    rresp <= resp_okay;
                end
                default: begin
                    rdata <= '0;
                    rresp <= resp_slverr;
                end
            endcase
        end
    end

    a_r_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> $stable(rdata)
    );

endmodule

`default_nettype wire

// ==== rtl/stack_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// stack word control FSM on the AXI4-Lite write channel
// latches a write, decodes and executes the word, returns the B response
//////////////////////////////////////////////////////////////////////
`default_nettype none

module stack_ctrl
    import stack_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        awvalid,
    input  wire logic [3:0]  awaddr,
    input  wire logic        wvalid,
    input  wire cell_t       wdata,
    input  wire logic        bready,
    input  wire logic        fault,
    output logic             awready,
    output logic             wready,
    output logic             bvalid,
    output resp_e            bresp,
    output opcode_e          op,
    output cell_t            push_data,
    output logic             exec,
    output logic             clr,
    output logic [1:0]       need,
    output logic [1:0]       delta,
    output logic             we_top,
    output logic             we_nos,
    output logic             err
);

    typedef enum logic [1:0] {st_idle, st_exec, st_resp} state_e;

    state_e     state;
    logic [3:0] addr_q;         // latched write offset
    cell_t      data_q;         // latched write data
    logic       valid_word;
    logic       wr_top;
    logic       wr_nos;
    logic       is_clr;

    // aw and w accepted together only
    assign awready   = (state == st_idle) && awvalid && wvalid;
    assign wready    = awready;
    assign exec      = (state == st_exec);
    assign push_data = data_q;
    assign op        = (addr_q == reg_data) ? op_push : opcode_e'(data_q[3:0]);

    always_comb begin
        need       = 2'd0;
        delta      = delta_zero;
        wr_top     = 1'b0;
        wr_nos     = 1'b0;
        is_clr     = 1'b0;
        valid_word = 1'b1;
        if (addr_q == reg_data) begin
            delta  = delta_inc;                 // push
            wr_top = 1'b1;
        end else if (addr_q == reg_cmd) begin
            case (op)
                op_drop: begin
                    need  = 2'd1;
                    delta = delta_dec;
                end
                op_dup: begin
                    need   = 2'd1;
                    delta  = delta_inc;
                    wr_top = 1'b1;
                end
                op_swap: begin
                    need   = 2'd2;
                    wr_top = 1'b1;
                    wr_nos = 1'b1;
                end
                op_over: begin
                    need   = 2'd2;
                    delta  = delta_inc;
                    wr_top = 1'b1;
                end
                op_add, op_sub, op_and, op_or, op_xor: begin
                    need   = 2'd2;
                    delta  = delta_dec;         // two in, one out
                    wr_top = 1'b1;
                end
                op_clr:  is_clr = 1'b1;
                default: valid_word = 1'b0;     // incl. push code via cmd
            endcase
        end else begin
            valid_word = 1'b0;                  // unmapped or read-only offset
        end
    end

    // refused words leave the cells alone
    assign we_top = exec && wr_top && !fault;
    assign we_nos = exec && wr_nos && !fault;
    assign clr    = exec && is_clr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= st_idle;
            bvalid <= 1'b0;
            err    <= 1'b0;
        end else begin
            case (state)
                st_idle: if (awready) state <= st_exec;
                st_exec: begin
                    state  <= st_resp;
                    bvalid <= 1'b1;
                    if (is_clr) err <= 1'b0;
                    else if (valid_word && fault) err <= 1'b1;  // sticky
                end
                default: if (bready) begin
                    state  <= st_idle;
                    bvalid <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (awready) begin
            addr_q <= awaddr;
            data_q <= wdata;
        end
        if (exec) begin
            bresp <= (!valid_word || fault) ? resp_slverr : resp_okay;
        end
    end

    a_b_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

endmodule

`default_nettype wire

// ==== rtl/stack_alu.sv ====
//////////////////////////////////////////////////////////////////////
// stack word datapath
// new top and new next cell values per opcode, combinational
//////////////////////////////////////////////////////////////////////
`default_nettype none

module stack_alu
    import stack_pkg::*;
(
    input  wire opcode_e op,
    input  wire cell_t   tos,
    input  wire cell_t   nos,
    input  wire cell_t   push_data,
    output cell_t        res_top,
    output cell_t        res_nos
);

    always_comb begin
        res_top = tos;                          // hold unless word writes
        res_nos = nos;
        case (op)
            op_push: res_top = push_data;
            op_dup:  res_top = tos;
            op_swap: begin
                res_top = nos;
                res_nos = tos;
            end
            op_over: res_top = nos;             // copy next onto top
            op_add:  res_top = nos + tos;       // wraps mod 2^32
            op_sub:  res_top = nos - tos;       // nos minus tos
            op_and:  res_top = nos & tos;
            op_or:   res_top = nos | tos;
            op_xor:  res_top = nos ^ tos;
            default: begin
                res_top = tos;                  // drop, clr, unused codes
                res_nos = nos;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/stack_ptr.sv ====
//////////////////////////////////////////////////////////////////////
// stack depth counter
// checks operand and room needs, derives current and next cell addresses
//////////////////////////////////////////////////////////////////////
`default_nettype none

module stack_ptr
    import stack_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               exec,           // one-cycle word strobe
    input  wire logic               clr,
    input  wire logic [1:0]         need,           // operands required
    input  wire logic [1:0]         delta,          // depth step code
    output logic                    fault,
    output logic [depth_w-1:0]      depth,
    output logic [addr_w-1:0]       top_addr,
    output logic [addr_w-1:0]       nos_addr,
    output logic [addr_w-1:0]       new_top_addr,
    output logic [addr_w-1:0]       new_nos_addr
);

    logic [depth_w-1:0] depth_q;
    logic [depth_w-1:0] depth_nx;       // depth after this word
    logic [depth_w-1:0] cur_top;
    logic [depth_w-1:0] cur_nos;
    logic [depth_w-1:0] nx_top;
    logic [depth_w-1:0] nx_nos;
    logic               full;

    assign full     = (depth_q == depth_w'(stack_pkg::depth));
    assign depth_nx = depth_q + {{(depth_w - 2){delta[1]}}, delta};    // sign extended step

    // underflow or overflow, word gets refused
    assign fault = ({3'b000, need} > depth_q) || ((delta == delta_inc) && full);

    // top sits at depth-1, next at depth-2, wrapping when shallow
    assign cur_top = depth_q - depth_w'(1);
    assign cur_nos = depth_q - depth_w'(2);
    assign nx_top  = depth_nx - depth_w'(1);
    assign nx_nos  = depth_nx - depth_w'(2);

    assign top_addr     = cur_top[addr_w-1:0];
    assign nos_addr     = cur_nos[addr_w-1:0];
    assign new_top_addr = nx_top[addr_w-1:0];
    assign new_nos_addr = nx_nos[addr_w-1:0];
    assign depth        = depth_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            depth_q <= '0;
        end else if (clr) begin
            depth_q <= '0;                      // empties stack
        end else if (exec && !fault) begin
            depth_q <= depth_nx;
        end
    end

    a_depth_bound: assert property (
        @(posedge clk) disable iff (!arst_n) depth_q <= depth_w'(stack_pkg::depth)
    );

endmodule

`default_nettype wire

// ==== rtl/stack_mem.sv ====
//////////////////////////////////////////////////////////////////////
// stack cell array, LUT based
// two combinational reads (top, next) and two clocked writes
//////////////////////////////////////////////////////////////////////
`default_nettype none

module stack_mem
    import stack_pkg::*;
(
    input  wire logic              clk,
    input  wire logic [addr_w-1:0] top_addr,    // current top cell
    input  wire logic [addr_w-1:0] nos_addr,    // current next cell
    input  wire logic              we_top,
    input  wire logic [addr_w-1:0] wtop_addr,
    input  wire cell_t             wtop_data,
    input  wire logic              we_nos,
    input  wire logic [addr_w-1:0] wnos_addr,
    input  wire cell_t             wnos_data,
    output cell_t                  tos,
    output cell_t                  nos
);

    cell_t cells [depth];   // no reset on contents

    // async reads so a word finishes in its single exec cycle
    assign tos = cells[top_addr];
    assign nos = cells[nos_addr];

    always_ff @(posedge clk) begin
        if (we_top) begin
            cells[wtop_addr] <= wtop_data;      // new top
        end
        if (we_nos) begin
            cells[wnos_addr] <= wnos_data;      // swap only
        end
    end

    // both ports land on distinct cells, else one write would be lost
    a_wr_ports_distinct: assert property (
        @(posedge clk) !(we_top && we_nos && (wtop_addr == wnos_addr))
    );

endmodule

`default_nettype wire

// ==== rtl/stack_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// stack coprocessor shared definitions
// sizes, register map, stack word opcodes and bus response codes
//////////////////////////////////////////////////////////////////////
`default_nettype none

package stack_pkg;

    localparam int depth   = 16;                  // stack cells
    localparam int cell_w  = 32;                  // bits per cell
    localparam int depth_w = $clog2(depth + 1);   // holds 0..depth
    localparam int addr_w  = $clog2(depth);       // cell index

    typedef logic [cell_w-1:0] cell_t;

    typedef enum logic [3:0] {
        op_drop = 4'd0,
        op_dup  = 4'd1,
        op_swap = 4'd2,
        op_over = 4'd3,
        op_add  = 4'd4,
        op_sub  = 4'd5,     // nos - tos
        op_and  = 4'd6,
        op_or   = 4'd7,
        op_xor  = 4'd8,
        op_clr  = 4'd9,
        op_push = 4'd15     // from a data register write only
    } opcode_e;

    localparam logic [3:0] reg_cmd    = 4'h0;   // write: opcode in bits 3..0
    localparam logic [3:0] reg_data   = 4'h4;   // write: push cell
    localparam logic [3:0] reg_tos    = 4'h8;   // read: top cell, 0 if empty
    localparam logic [3:0] reg_status = 4'hC;   // read: status word

    // status word: depth in 4..0, empty 8, full 9, sticky err 16, rest zero
    localparam int st_empty = 8;
    localparam int st_full  = 9;
    localparam int st_err   = 16;

    localparam logic [1:0] delta_zero = 2'b00;  // depth unchanged
    localparam logic [1:0] delta_inc  = 2'b01;  // +1
    localparam logic [1:0] delta_dec  = 2'b11;  // -1, two's complement

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_e;

endpackage

`default_nettype wire
